// ==== sim/ifetch_input.txt ====
// words 0..63: memory image by address bits 7:2, bit 0 set marks a 64-bit low half
// words 64..67: redirect targets; words 68..72: test modes, bit 0 bus jitter, bit 1 cpu stall
00000010 10000021 11000032 00100044 20000051 22000062 00000073 33000084
00a00090 4000a0a1 44000ab2 00b000c4 00c000d6 500000e1 55000ef2 00d00f08
01000100 60001011 66001122 01200134 01300146 70001151 77001162 01400178
01500180 80001191 880011a2 016001b4 900011c1 990011d2 017001e4 018001f6
a0002001 aa002012 01900224 01a00236 b0002241 bb002252 01b00264 01c00276
c0002281 cc002292 01d002a4 d00022b1 dd0022c2 01e002d4 01f002e6 e00022f1
ee002302 02000314 02100326 f0002331 ff002342 02200354 02300366 02400378
02500380 02600392 130023a1 1300a3b2 027003c4 028003d6 140023e1 1400a3f5
// redirect targets
00000020 00001084 fffffffc 000000b8
// modes for reset_stream, bus_jitter, cpu_stall, redirect, halt
00000000 00000001 00000002 00000003 00000001

// ==== sources.f ====
verilog/fetch_pkg.sv
verilog/fetch_fifo.sv
verilog/fetch_bus_master.sv
verilog/insn_assembler.sv
verilog/ifetch.sv
sim/tb_ifetch.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_ifetch \
  -f sources.f -Mdir obj_dir -o tb_ifetch_sim

./obj_dir/tb_ifetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
fi
exit 1

// ==== sim/tb_ifetch.sv ====
`timescale 1ns/1ps

module tb_ifetch;

  localparam int MEM_WORDS = 64;
  localparam int N_TARGETS = 4;
  localparam int N_TESTS = 5;
  localparam int DATA_WORDS = MEM_WORDS + N_TARGETS + N_TESTS;
  localparam int STEP_LIMIT = 2000; // cycles allowed per wait loop

  logic             clk_i;
  logic             rst_i;
  logic             stall_i;
  logic             pc_set_i;
  fetch_pkg::addr_t pc_in_i;
  logic             halt_i;
  fetch_pkg::word_t wb_dat_i;
  logic             wb_ack_i;
  logic             wb_stall_i;
  fetch_pkg::insn_t ir_o;
  fetch_pkg::addr_t pc_o;
  logic             wb_cyc_o;
  logic             wb_stb_o;
  fetch_pkg::addr_t wb_adr_o;

  fetch_pkg::word_t stim [DATA_WORDS]; // memory image, targets, test modes
  integer seed;
  int step_no;
  int burst_cnt;
  int insn_cnt;
  bit rand_bus; // ack jitter and wb_stall_i
  bit rand_cpu; // random stall_i
  string test_name;
  fetch_pkg::addr_t ack_adr_q[$];
  int ack_due_q[$];
  fetch_pkg::addr_t walk_pc;
  fetch_pkg::insn_t last_ir;
  fetch_pkg::addr_t last_pc;

  ifetch u_dut (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .pc_set_i   (pc_set_i),
    .pc_in_i    (pc_in_i),
    .halt_i     (halt_i),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i),
    .wb_stall_i (wb_stall_i),
    .ir_o       (ir_o),
    .pc_o       (pc_o),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_adr_o   (wb_adr_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_insn(input string name, input fetch_pkg::insn_t exp,
                            input fetch_pkg::insn_t act);
    if (act !== exp)
      stop_run($sformatf("ERROR %s: ir expected %h actual %h", name, exp, act));
  endtask

  task automatic check_pc(input string name, input fetch_pkg::addr_t exp,
                          input fetch_pkg::addr_t act);
    if (act !== exp)
      stop_run($sformatf("ERROR %s: pc expected %h actual %h", name, exp, act));
  endtask

  task automatic check_bus_idle(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_run($sformatf("ERROR %s: bus line expected %b actual %b", name, exp, act));
  endtask

  function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t adr);
    return stim[adr[7:2]]; // 64-word image repeats over the address space
  endfunction

  // expected instruction at pc and the pc that follows it
  task automatic walk(input fetch_pkg::addr_t pc, output fetch_pkg::insn_t insn,
                      output fetch_pkg::addr_t next_pc);
    fetch_pkg::word_t w;
    w = mem_word(pc);
    if (w[0])
    begin
      insn = {mem_word(pc + 32'd4), w}; // low half first
      next_pc = pc + 32'd8;
    end
    else
    begin
      insn = {32'h0, w};
      next_pc = pc + 32'd4;
    end
  endtask

  // one clock of output checks, memory model and CPU-side drive
  task automatic step_cycle(input logic set, input fetch_pkg::addr_t target,
                            input logic halt);
    fetch_pkg::insn_t exp_ir;
    fetch_pkg::addr_t exp_pc;
    fetch_pkg::addr_t adr;
    @(negedge clk_i);
    step_no++;
    if (stall_i)
    begin
      check_insn({test_name, " hold"}, last_ir, ir_o);
      check_pc({test_name, " hold"}, last_pc, pc_o);
    end
    else if (ir_o != '0)
    begin
      walk(walk_pc, exp_ir, exp_pc);
      check_insn(test_name, exp_ir, ir_o);
      check_pc(test_name, exp_pc, pc_o);
      walk_pc = exp_pc;
      insn_cnt++;
    end
    last_ir = ir_o;
    last_pc = pc_o;

    wb_ack_i = 1'b0;
    wb_dat_i = '0;
    if ((ack_due_q.size() > 0) && (ack_due_q[0] <= step_no))
    begin
      adr = ack_adr_q.pop_front();
      void'(ack_due_q.pop_front());
      wb_ack_i = 1'b1;
      wb_dat_i = mem_word(adr);
    end
    wb_stall_i = rand_bus && (($random(seed) & 3) == 0);

    stall_i = rand_cpu && !set && (($random(seed) & 3) == 0);
    pc_set_i = set;
    pc_in_i = target;
    halt_i = halt;
    if (set)
      walk_pc = target;

    #1; // let stb settle after pc_set_i
    if (!wb_cyc_o)
      burst_cnt = 0;
    else if (wb_stb_o && !wb_stall_i)
    begin
      burst_cnt++;
      if (burst_cnt > fetch_pkg::FETCH_BURST)
        stop_run($sformatf("%s: more than %0d requests in one bus cycle",
                           test_name, fetch_pkg::FETCH_BURST));
      ack_adr_q.push_back(wb_adr_o);
      ack_due_q.push_back(step_no + (rand_bus ? 1 + ($unsigned($random(seed)) % 3) : 1));
    end
  endtask

  task automatic apply_reset;
    @(negedge clk_i);
    rst_i = 1'b1;
    stall_i = 1'b0;
    pc_set_i = 1'b0;
    pc_in_i = '0;
    halt_i = 1'b0;
    wb_ack_i = 1'b0;
    wb_stall_i = 1'b0;
    wb_dat_i = '0;
    ack_adr_q.delete();
    ack_due_q.delete();
    burst_cnt = 0;
    walk_pc = fetch_pkg::RESET_PC;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
  endtask

  task automatic begin_test(input int idx, input string name);
    test_name = name;
    rand_bus = stim[MEM_WORDS + N_TARGETS + idx][0];
    rand_cpu = stim[MEM_WORDS + N_TARGETS + idx][1];
    $display("running %s", name);
    apply_reset;
    insn_cnt = 0;
  endtask

  task automatic run_insns(input int count);
    int goal;
    int n;
    goal = insn_cnt + count;
    n = 0;
    while (insn_cnt < goal)
    begin
      step_cycle(1'b0, '0, 1'b0);
      n++;
      if (n > STEP_LIMIT)
        stop_run($sformatf("%s: timed out with %0d of %0d instructions seen",
                           test_name, insn_cnt, goal));
    end
  endtask

  initial
  begin
    int n;
    clk_i = 1'b0;
    rst_i = 1'b1;
    stall_i = 1'b0;
    pc_set_i = 1'b0;
    pc_in_i = '0;
    halt_i = 1'b0;
    wb_dat_i = '0;
    wb_ack_i = 1'b0;
    wb_stall_i = 1'b0;
    seed = 32'h8896_dacb;
    step_no = 0;
    $readmemh("sim/ifetch_input.txt", stim);

    begin_test(0, "reset_stream");
    check_bus_idle({test_name, " cyc"}, 1'b0, wb_cyc_o);
    check_bus_idle({test_name, " stb"}, 1'b0, wb_stb_o);
    check_insn({test_name, " reset"}, '0, ir_o);
    run_insns(20);

    begin_test(1, "bus_jitter");
    run_insns(40);

    begin_test(2, "cpu_stall");
    run_insns(40);

    begin_test(3, "redirect");
    run_insns(5);
    for (int i = 0; i < N_TARGETS; i++)
    begin
      step_cycle(1'b1, stim[MEM_WORDS + i], 1'b0);
      run_insns(6);
      repeat (i + 1) step_cycle(1'b0, '0, 1'b0); // vary where the next redirect lands
    end

    begin_test(4, "halt");
    run_insns(10);
    step_cycle(1'b0, '0, 1'b1);
    n = 0;
    while (wb_cyc_o)
    begin
      step_cycle(1'b0, '0, 1'b0);
      n++;
      if (n > STEP_LIMIT)
        stop_run("halt: wb_cyc_o stayed high after halt_i");
    end
    repeat (100)
    begin
      step_cycle(1'b0, '0, 1'b0);
      check_bus_idle({test_name, " cyc"}, 1'b0, wb_cyc_o);
    end
    check_insn({test_name, " dry"}, '0, ir_o);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== verilog/ifetch.sv ====
`timescale 1ns/1ps

module ifetch (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             stall_i,
  input  logic             pc_set_i,
  input  fetch_pkg::addr_t pc_in_i,
  input  logic             halt_i,
  input  fetch_pkg::word_t wb_dat_i,
  input  logic             wb_ack_i,
  input  logic             wb_stall_i,
  output fetch_pkg::insn_t ir_o,
  output fetch_pkg::addr_t pc_o,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output fetch_pkg::addr_t wb_adr_o
);

  logic              fifo_push;
  fetch_pkg::word_t  fifo_din;
  logic              fifo_flush;
  logic              fifo_pop;
  fetch_pkg::word_t  fifo_dout;
  logic              fifo_empty;
  fetch_pkg::level_t fifo_level;

  fetch_bus_master u_bus (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .pc_set_i     (pc_set_i),
    .pc_in_i      (pc_in_i),
    .halt_i       (halt_i),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .wb_stall_i   (wb_stall_i),
    .fifo_level_i (fifo_level),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_adr_o     (wb_adr_o),
    .fifo_push_o  (fifo_push),
    .fifo_din_o   (fifo_din),
    .fifo_flush_o (fifo_flush)
  );

  fetch_fifo #(
    .payload_t (fetch_pkg::word_t)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (fifo_flush),
    .push_i  (fifo_push),
    .din_i   (fifo_din),
    .pop_i   (fifo_pop),
    .dout_o  (fifo_dout),
    .empty_o (fifo_empty),
    .full_o  (), // level already limits bursts
    .level_o (fifo_level)
  );

  insn_assembler u_asm (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (stall_i),
    .pc_set_i     (pc_set_i),
    .pc_in_i      (pc_in_i),
    .fifo_dout_i  (fifo_dout),
    .fifo_empty_i (fifo_empty),
    .fifo_pop_o   (fifo_pop),
    .ir_o         (ir_o),
    .pc_o         (pc_o)
  );

endmodule

// ==== verilog/insn_assembler.sv ====
`timescale 1ns/1ps

module insn_assembler (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             stall_i,
  input  logic             pc_set_i,
  input  fetch_pkg::addr_t pc_in_i,
  input  fetch_pkg::word_t fifo_dout_i,
  input  logic             fifo_empty_i,
  output logic             fifo_pop_o,
  output fetch_pkg::insn_t ir_o,
  output fetch_pkg::addr_t pc_o
);

  typedef enum logic {
    S_FIRST,
    S_SECOND
  } state_t;

  state_t state_q, state_d;

  fetch_pkg::insn_t ir_q, ir_d;
  fetch_pkg::addr_t pc_q, pc_d;
  fetch_pkg::word_t low_q, low_d; // low half of a 64-bit insn

  assign fifo_pop_o = !stall_i && !fifo_empty_i && !pc_set_i;
  assign ir_o = ir_q;
  assign pc_o = pc_q;

  always_comb
  begin
    state_d = state_q;
    ir_d = ir_q;
    pc_d = pc_q;
    low_d = low_q;

    if (pc_set_i)
    begin
      pc_d = pc_in_i;
      state_d = S_FIRST; // pending low half is dropped
      if (!stall_i)
        ir_d = '0;
    end
    else if (!stall_i)
    begin
      if (fifo_empty_i)
        ir_d = '0; // starved so emit a bubble
      else
      begin
        pc_d = pc_q + fetch_pkg::WORD_BYTES;
        if (state_q == S_SECOND)
        begin
          ir_d = {fifo_dout_i, low_q};
          state_d = S_FIRST;
        end
        else if (fifo_dout_i[0])
        begin
          low_d = fifo_dout_i;
          ir_d = '0;
          state_d = S_SECOND;
        end
        else
          ir_d = {32'h0, fifo_dout_i};
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    low_q <= low_d;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= S_FIRST;
      ir_q <= '0;
      pc_q <= fetch_pkg::RESET_PC;
    end
    else
    begin
      state_q <= state_d;
      ir_q <= ir_d;
      pc_q <= pc_d;
    end
  end

  a_ir_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> $stable(ir_o))
    else $error("ir_o changed while stalled");

endmodule

// ==== verilog/fetch_bus_master.sv ====
`timescale 1ns/1ps

module fetch_bus_master (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              pc_set_i,
  input  fetch_pkg::addr_t  pc_in_i,
  input  logic              halt_i,
  input  fetch_pkg::word_t  wb_dat_i,
  input  logic              wb_ack_i,
  input  logic              wb_stall_i,
  input  fetch_pkg::level_t fifo_level_i,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output fetch_pkg::addr_t  wb_adr_o,
  output logic              fifo_push_o,
  output fetch_pkg::word_t  fifo_din_o,
  output logic              fifo_flush_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_DRAIN,
    S_HALT
  } state_t;

  state_t state_q, state_d;

  fetch_pkg::addr_t adr_q, adr_d;
  fetch_pkg::level_t req_q, req_d; // requests accepted in this burst
  fetch_pkg::level_t out_q, out_d; // acks still owed by the slave
  fetch_pkg::level_t disc_q, disc_d; // stale acks left to drop
  logic halt_q, halt_d;

  logic accept;
  logic [fetch_pkg::LEVEL_W:0] room_need;

  assign wb_cyc_o = (state_q == S_FETCH) || (state_q == S_DRAIN);
  assign wb_stb_o = (state_q == S_FETCH) && !pc_set_i; // redirect drops stb at once
  assign wb_adr_o = adr_q;
  assign accept = wb_stb_o && !wb_stall_i;

  assign fifo_din_o = wb_dat_i;
  assign fifo_push_o = wb_ack_i && (disc_q == '0);
  assign fifo_flush_o = pc_set_i;

  // words buffered or in flight plus one more burst
  assign room_need = fifo_level_i + out_q + fetch_pkg::level_t'(fetch_pkg::FETCH_BURST);

  always_comb
  begin
    state_d = state_q;
    adr_d = adr_q;
    req_d = req_q;
    out_d = out_q + fetch_pkg::level_t'(accept) - fetch_pkg::level_t'(wb_ack_i);
    disc_d = disc_q;
    halt_d = halt_q | halt_i;

    if (wb_ack_i && (disc_q != '0))
      disc_d = disc_q - 1'b1;

    case (state_q)
      S_IDLE:
      begin
        if (halt_d)
          state_d = S_HALT;
        else if (room_need <= fetch_pkg::FIFO_DEPTH)
        begin
          state_d = S_FETCH;
          req_d = '0;
        end
      end
      S_FETCH:
      begin
        if (accept)
        begin
          adr_d = adr_q + fetch_pkg::WORD_BYTES;
          req_d = req_q + 1'b1;
          if (req_q == fetch_pkg::level_t'(fetch_pkg::FETCH_BURST - 1))
            state_d = S_DRAIN;
        end
      end
      S_DRAIN:
      begin
        if (out_d == '0)
          state_d = halt_d ? S_HALT : S_IDLE; // cyc low for at least a cycle
      end
      default:
        state_d = S_HALT; // only reset leaves
    endcase

    if (pc_set_i)
    begin
      adr_d = pc_in_i;
      disc_d = out_d; // everything still owed is stale
      if (state_q == S_FETCH)
        state_d = S_DRAIN;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= S_IDLE;
      adr_q <= fetch_pkg::RESET_PC;
      req_q <= '0;
      out_q <= '0;
      disc_q <= '0;
      halt_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      adr_q <= adr_d;
      req_q <= req_d;
      out_q <= out_d;
      disc_q <= disc_d;
      halt_q <= halt_d;
    end
  end

  // cyc covers every request and every ack still owed
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    (wb_stb_o || (out_q != '0)) |-> wb_cyc_o)
    else $error("stb or owed ack without cyc");

  // the slave may only ack what was accepted earlier
  a_ack_owed: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_i |-> (out_q != '0))
    else $error("ack with nothing outstanding");

endmodule

// ==== verilog/fetch_fifo.sv ====
`timescale 1ns/1ps

module fetch_fifo #(
  parameter type payload_t = fetch_pkg::word_t
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              flush_i,
  input  logic              push_i,
  input  payload_t          din_i,
  input  logic              pop_i,
  output payload_t          dout_o,
  output logic              empty_o,
  output logic              full_o,
  output fetch_pkg::level_t level_o
);

  payload_t mem [fetch_pkg::FIFO_DEPTH];

  logic [fetch_pkg::PTR_W-1:0] wr_ptr;
  logic [fetch_pkg::PTR_W-1:0] rd_ptr;
  fetch_pkg::level_t count;

  logic do_push;
  logic do_pop;

  assign do_push = push_i && !full_o && !flush_i; // flush wins over push
  assign do_pop = pop_i && !empty_o && !flush_i;

  assign empty_o = (count == '0);
  assign full_o = (count == fetch_pkg::level_t'(fetch_pkg::FIFO_DEPTH));
  assign level_o = count;
  assign dout_o = mem[rd_ptr]; // head word

  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem[wr_ptr] <= din_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else if (flush_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i && !flush_i |-> !full_o)
    else $error("fifo push while full");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i && !flush_i |-> !empty_o)
    else $error("fifo pop while empty");

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

  // bus word as fetched
  typedef logic [31:0] word_t;

  // byte address
  typedef logic [31:0] addr_t;

  // decode-stage instruction where zero is a bubble
  typedef logic [63:0] insn_t;

  localparam addr_t RESET_PC = 32'hfffffff8;

  localparam addr_t WORD_BYTES = 32'd4; // address step per word

  localparam int FETCH_BURST = 4; // requests per burst
  localparam int FIFO_DEPTH = 16;

  localparam int LEVEL_W = 5; // holds 0..FIFO_DEPTH
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // FIFO fill level and the bus-side request counters
  typedef logic [LEVEL_W-1:0] level_t;

endpackage
